/* bench/tb_noncomp_slice.sv */
// --------------------
// Testbench for the non-computational FP slice
// LFSR stimulus, reference model and in-order scoreboard
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tb_noncomp_slice;

  import fpslice_pkg::*;

  localparam int N_SIGN       = 120;
  localparam int N_MINMAX     = 160;
  localparam int N_MASK       = 80;
  localparam int N_BACKPRESS  = 160;
  localparam int N_PRE_FLUSH  = 24;
  localparam int N_POST_FLUSH = 56;
  localparam int TOTAL_ITEMS  = N_SIGN + N_MINMAX + N_MASK + N_BACKPRESS
                                + N_PRE_FLUSH + N_POST_FLUSH;
  localparam int CYCLE_LIMIT  = TOTAL_ITEMS * 10 + 2000; // Ten cycles per item plus margin

  localparam int OPS_SIGN   = 0;
  localparam int OPS_MINMAX = 1;
  localparam int OPS_ANY    = 2;

  typedef struct packed {
    logic [63:0] result;
    logic [4:0]  status;
  } expect_t;

  typedef struct packed {
    logic [3:0] tag;
    expect_t    exp;
  } item_t;

  logic             clk, rst_n, flush;
  logic [1:0][63:0] operands;
  noncomp_op_e      op_sel;
  fp_format_e       fmt_sel;
  logic             vec_op, in_valid, in_ready;
  logic [3:0]       tag_in, tag_out, simd_mask;
  logic [63:0]      result;
  status_t          status;
  logic             out_valid, out_ready, busy;

  item_t       exp_q[$];
  logic [15:0] stim_lfsr = 16'd15;
  logic [15:0] bp_lfsr   = 16'd15;
  logic [3:0]  next_tag  = 4'd0;
  logic        bp_on     = 1'b0;
  logic        hold_out  = 1'b0;
  int          err_cnt = 0, check_cnt = 0, test_err_base = 0, cycle_cnt = 0;

  noncomp_slice dut (
    .clk_i          ( clk       ),
    .rst_n_i        ( rst_n     ),
    .operands_i     ( operands  ),
    .op_i           ( op_sel    ),
    .fmt_i          ( fmt_sel   ),
    .vectorial_op_i ( vec_op    ),
    .tag_i          ( tag_in    ),
    .simd_mask_i    ( simd_mask ),
    .in_valid_i     ( in_valid  ),
    .in_ready_o     ( in_ready  ),
    .flush_i        ( flush     ),
    .result_o       ( result    ),
    .status_o       ( status    ),
    .tag_o          ( tag_out   ),
    .out_valid_o    ( out_valid ),
    .out_ready_i    ( out_ready ),
    .busy_o         ( busy      )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Random source
  // --------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16 14 13 11
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  // Half of the values are NaN, sNaN, zero or infinity
  function automatic logic [31:0] gen_value(input logic is16);
    int unsigned fw, mw;
    logic [31:0] man_mask, exp_mask, qbit, sgn, v;
    logic [2:0]  cls;
    fw       = is16 ? 16 : 32;
    mw       = is16 ? 10 : 23;
    man_mask = (32'h1 << mw) - 32'h1;
    exp_mask = ((32'h1 << (fw - 1)) - 32'h1) & ~man_mask;
    qbit     = 32'h1 << (mw - 1);
    cls      = 3'(rand_bits(3));
    sgn      = rand_bits(1) << (fw - 1);
    case (cls)
      3'd0:    v = sgn | exp_mask | qbit | rand_bits(mw - 1);
      3'd1:    v = sgn | exp_mask | rand_bits(mw - 1) | 32'h1; // Quiet bit clear
      3'd2:    v = sgn;
      3'd3:    v = sgn | exp_mask;
      default: v = rand_bits(fw);
    endcase
    return v;
  endfunction

  function automatic logic [63:0] gen_operand(input fp_format_e fmt);
    logic [63:0] w;
    w = '0;
    if (fmt == FP16) begin
      for (int i = 0; i < 4; i++) w[i*16 +: 16] = 16'(gen_value(1'b1));
    end else begin
      for (int i = 0; i < 2; i++) w[i*32 +: 32] = gen_value(1'b0);
    end
    return w;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  // Returns the NV flag above the lane value
  function automatic logic [32:0] lane_ref(input logic [31:0] x, input logic [31:0] y,
                                           input noncomp_op_e op, input logic is16);
    int unsigned sb;
    logic [31:0] man_mask, mag_mask, exp_mask, qbit, qnan, kx, ky, r;
    logic        xs, ys, xn, yn, xsn, ysn, minmax;
    sb       = is16 ? 15 : 31;
    man_mask = is16 ? 32'h0000_03ff : 32'h007f_ffff;
    mag_mask = (32'h1 << sb) - 32'h1;
    exp_mask = mag_mask & ~man_mask;
    qbit     = (man_mask + 32'h1) >> 1;
    qnan     = exp_mask | qbit;
    xs       = x[sb];
    ys       = y[sb];
    xn       = ((x & exp_mask) == exp_mask) && ((x & man_mask) != 32'h0);
    yn       = ((y & exp_mask) == exp_mask) && ((y & man_mask) != 32'h0);
    xsn      = xn && ((x & qbit) == 32'h0);
    ysn      = yn && ((y & qbit) == 32'h0);
    // Ordering key, negatives below positives and -0 just below +0
    kx       = xs ? (~x & mag_mask) : (x | (32'h1 << sb));
    ky       = ys ? (~y & mag_mask) : (y | (32'h1 << sb));
    minmax   = (op == FMIN) || (op == FMAX);
    case (op)
      SGNJ:  r = (x & mag_mask) | ({31'b0, ys} << sb);
      SGNJN: r = (x & mag_mask) | ({31'b0, ~ys} << sb);
      SGNJX: r = (x & mag_mask) | ({31'b0, xs ^ ys} << sb);
      default: begin
        if (xn && yn)        r = qnan;
        else if (xn)         r = y;
        else if (yn)         r = x;
        else if (op == FMIN) r = (kx <= ky) ? x : y;
        else                 r = (kx >= ky) ? x : y;
      end
    endcase
    return {minmax & (xsn | ysn), r};
  endfunction

  function automatic expect_t ref_model(input logic [63:0] a, input logic [63:0] b,
                                        input noncomp_op_e op, input fp_format_e fmt,
                                        input logic vec, input logic [3:0] mask);
    expect_t     e;
    int unsigned fw, lanes;
    logic [63:0] fmask;
    logic [31:0] x, y;
    logic [32:0] lr;
    fw       = (fmt == FP16) ? 16 : 32;
    lanes    = vec ? 64 / fw : 1;
    fmask    = (64'h1 << fw) - 64'h1;
    e.result = '1; // Unused slots stay NaN-boxed
    e.status = '0;
    for (int unsigned l = 0; l < lanes; l++) begin
      x        = 32'((a >> (l * fw)) & fmask);
      y        = 32'((b >> (l * fw)) & fmask);
      lr       = lane_ref(x, y, op, fmt == FP16);
      e.result = (e.result & ~(fmask << (l * fw))) | ({32'b0, lr[31:0]} << (l * fw));
      if (lr[32] && mask[l]) e.status[4] = 1'b1; // NV only from enabled lanes
    end
    return e;
  endfunction

  // --------------------
  // Checking
  // --------------------
  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test done: %s, %0d errors", name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  always @(negedge clk) begin : scoreboard
    item_t entry, head;
    if (rst_n && flush) begin
      exp_q.delete(); // Everything in flight is dropped
    end else if (rst_n) begin
      if (in_valid && in_ready) begin
        entry.tag = tag_in;
        entry.exp = ref_model(operands[0], operands[1], op_sel, fmt_sel, vec_op, simd_mask);
        exp_q.push_back(entry);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Error at %0t: an item left the DUT while none was expected", $time);
        end else begin
          head = exp_q.pop_front();
          check_equal(64'(tag_out), 64'(head.tag), "tag");
          check_equal(result, head.exp.result, $sformatf("result of tag %0d", head.tag));
          check_equal(64'(status), 64'(head.exp.status), $sformatf("status of tag %0d", head.tag));
        end
      end
    end
  end

  always @(posedge clk) begin : ready_drive
    bp_lfsr <= lfsr_step(bp_lfsr);
    if (hold_out)   out_ready <= 1'b0;
    else if (bp_on) out_ready <= bp_lfsr[0];
    else            out_ready <= 1'b1;
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // --------------------
  // Driving
  // --------------------
  task automatic send_item(input logic [63:0] a, input logic [63:0] b, input noncomp_op_e op,
                           input fp_format_e fmt, input logic vec, input logic [3:0] mask);
    @(posedge clk);
    operands  <= {b, a};
    op_sel    <= op;
    fmt_sel   <= fmt;
    vec_op    <= vec;
    simd_mask <= mask;
    tag_in    <= next_tag;
    in_valid  <= 1'b1;
    next_tag  = next_tag + 4'd1;
    @(negedge clk);
    while (!in_ready) @(negedge clk); // Taken on the next rising edge
  endtask

  task automatic random_item(input fp_format_e fmt, input logic vec, input int op_kind);
    logic [63:0] a, b;
    noncomp_op_e op;
    a = gen_operand(fmt);
    b = gen_operand(fmt);
    case (op_kind)
      OPS_SIGN:   op = noncomp_op_e'(3'(rand_bits(2) % 3));
      OPS_MINMAX: op = (rand_bits(1) != 0) ? FMAX : FMIN;
      default:    op = noncomp_op_e'(3'(rand_bits(3) % 5));
    endcase
    send_item(a, b, op, fmt, vec, 4'(rand_bits(4)));
  endtask

  task automatic drain();
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    while (exp_q.size() != 0 || busy) @(negedge clk);
  endtask

  task automatic do_flush();
    hold_out = 1'b1; // Output stays still during the flush cycle
    @(posedge clk);
    in_valid <= 1'b0;
    flush    <= 1'b1;
    @(negedge clk);
    check_equal(64'(busy), 64'd1, "busy before flush"); // Last item was just taken
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_equal(64'(busy), 64'd0, "busy after flush");
    check_equal(64'(out_valid), 64'd0, "out_valid after flush");
    hold_out = 1'b0;
  endtask

  initial begin : stimulus
    rst_n     = 1'b0;
    flush     = 1'b0;
    operands  = '0;
    op_sel    = SGNJ;
    fmt_sel   = FP32;
    vec_op    = 1'b0;
    tag_in    = '0;
    simd_mask = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_equal(64'(out_valid), 64'd0, "out_valid after reset");
    check_equal(64'(busy), 64'd0, "busy after reset");
    check_equal(64'(in_ready), 64'd1, "in_ready after reset");
    report_test("reset state");

    for (int i = 0; i < N_SIGN; i++) random_item(fp_format_e'(i[0]), 1'b0, OPS_SIGN);
    drain();
    report_test("scalar sign injection");

    // Signed zeros and NaN pairs first
    send_item(64'h8000_0000_0000_0000, 64'h0000_0000_8000_0000, FMIN, FP32, 1'b1, 4'hf);
    send_item(64'h8000_0000_0000_0000, 64'h0000_0000_8000_0000, FMAX, FP32, 1'b1, 4'hf);
    send_item(64'h7c01_7e00_8000_3c00, 64'h3c00_7c01_0000_fe00, FMIN, FP16, 1'b1, 4'hf);
    send_item(64'h7c01_7e00_8000_3c00, 64'h3c00_7c01_0000_fe00, FMAX, FP16, 1'b1, 4'hf);
    for (int i = 4; i < N_MINMAX; i++) random_item(fp_format_e'(i[0]), 1'b1, OPS_MINMAX);
    drain();
    report_test("vector min and max");

    for (int i = 0; i < N_MASK; i++) random_item(fp_format_e'(i[1]), 1'b1, OPS_MINMAX);
    drain();
    report_test("SIMD mask");

    // Only FP16 vectors here, so every lane holds every item
    bp_on = 1'b1;
    for (int i = 0; i < N_BACKPRESS; i++) random_item(FP16, 1'b1, OPS_ANY);
    drain();
    bp_on = 1'b0;
    report_test("output back-pressure");

    bp_on = 1'b1;
    for (int i = 0; i < N_PRE_FLUSH; i++) random_item(FP16, 1'b1, OPS_ANY);
    do_flush();
    bp_on = 1'b0;
    for (int i = 0; i < N_POST_FLUSH; i++) random_item(fp_format_e'(i[0]), i[1], OPS_ANY);
    drain();
    report_test("flush mid-stream");

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
source/fpslice_pkg.sv
source/lane_result_if.sv
source/slice_pipe.sv
source/noncomp_lane.sv
source/result_packer.sv
source/noncomp_slice.sv
bench/tb_noncomp_slice.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_noncomp_slice \
  -f project.f -o sim_noncomp > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_noncomp > sim.log 2>&1

grep -q "ALL TESTS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* source/fpslice_pkg.sv */
// --------------------
// Shared types for the non-computational FP slice
// Formats, operations, flags and lane layout helpers
// --------------------

`default_nettype none

package fpslice_pkg;

  // --------------------
  // Formats and operations
  // --------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned NUM_FORMATS = 2;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } noncomp_op_e;

  // IEEE exception flags, NV in the top bit
  typedef struct packed {
    logic nv; // Invalid operation
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  // Travels with lane 0 down the pipe
  typedef struct packed {
    logic       is_vector;
    fp_format_e fmt;
  } aux_t;

  localparam int unsigned MAX_LANE_WIDTH = 32;

  // --------------------
  // Helpers
  // --------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP32) ? 32 : 16;
  endfunction

  // One lane per 16 bits of datapath
  function automatic int unsigned num_lanes(int unsigned width);
    return width / fp_width(FP16);
  endfunction

  // Lower lanes are wide enough for FP32, all lanes take FP16
  function automatic logic [NUM_FORMATS-1:0] lane_formats(int unsigned width,
                                                          int unsigned lane);
    logic [NUM_FORMATS-1:0] mask;
    mask       = '0;
    mask[FP32] = (lane < width / fp_width(FP32));
    mask[FP16] = (lane < width / fp_width(FP16));
    return mask;
  endfunction

endpackage

`default_nettype wire

/* source/lane_result_if.sv */
// --------------------
// Lane result bundle
// Per-lane result, status, mask and valid toward the packer
// --------------------

`timescale 1ns/100ps
`default_nettype none

interface lane_result_if #(
  parameter int unsigned NumLanes = 4
) ();

  logic [fpslice_pkg::MAX_LANE_WIDTH-1:0] lane_result [NumLanes];
  fpslice_pkg::status_t                   lane_status [NumLanes];
  logic [NumLanes-1:0]                    lane_mask;
  logic [NumLanes-1:0]                    lane_valid;
  fpslice_pkg::aux_t                      aux; // Written by lane 0 only

  // Each lane writes its own element
  modport lane_mp (
    output lane_result,
    output lane_status,
    output lane_mask,
    output lane_valid,
    output aux
  );

  modport packer_mp (
    input lane_result,
    input lane_status,
    input lane_mask,
    input lane_valid,
    input aux
  );

endinterface

`default_nettype wire

/* source/noncomp_lane.sv */
// --------------------
// Non-computational SIMD lane
// Sign injection and min/max, followed by the lane pipeline
// --------------------

`timescale 1ns/100ps
`default_nettype none

module noncomp_lane #(
  parameter int unsigned Width       = 64,
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4,
  parameter int unsigned LaneIdx     = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic [1:0][Width-1:0]      operands_i,
  input  fpslice_pkg::noncomp_op_e   op_i,
  input  fpslice_pkg::fp_format_e    fmt_i,
  input  fpslice_pkg::aux_t          aux_i,
  input  logic [TagWidth-1:0]        tag_i,
  input  logic                       mask_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       out_ready_i,
  output logic [TagWidth-1:0]        tag_o,
  output logic                       busy_o,
  lane_result_if.lane_mp             res
);

  import fpslice_pkg::*;

  localparam logic [NUM_FORMATS-1:0] LANE_FMTS  = lane_formats(Width, LaneIdx);
  localparam int unsigned            LANE_WIDTH = LANE_FMTS[FP32] ? fp_width(FP32)
                                                                  : fp_width(FP16);

  typedef struct packed {
    logic [LANE_WIDTH-1:0] result;
    status_t               status;
    logic                  mask;
  } body_t;

  typedef struct packed {
    body_t               body;
    logic [TagWidth-1:0] tag;
    aux_t                aux;
  } head_t;

  logic [1:0][LANE_WIDTH-1:0]             lane_ops;
  logic [NUM_FORMATS-1:0][LANE_WIDTH-1:0] fmt_result;
  logic [NUM_FORMATS-1:0]                 fmt_nv;
  status_t                                lane_status;
  body_t                                  body_in, body_out;
  logic                                   out_valid;
  logic [MAX_LANE_WIDTH-1:0]              lane_word;

  // --------------------
  // Operand slicing
  // --------------------
  always_comb begin : slice_operands
    for (int i = 0; i < 2; i++) begin
      lane_ops[i] = LANE_WIDTH'(operands_i[i] >> (LaneIdx * fp_width(fmt_i)));
    end
  end

  // --------------------
  // Per-format datapath
  // --------------------
  for (genvar f = 0; f < int'(NUM_FORMATS); f++) begin : gen_fmt
    localparam int unsigned FW       = fp_width(fp_format_e'(f));
    localparam int unsigned MAN_BITS = (FW == 32) ? 23 : 10;

    if (LANE_FMTS[f]) begin : gen_active
      logic [FW-1:0]         a, b, qnan, minmax;
      logic                  a_nan, b_nan, a_snan, b_snan;
      logic                  a_lt_b, take_a;
      logic [LANE_WIDTH-1:0] res_word;

      assign a = lane_ops[0][FW-1:0];
      assign b = lane_ops[1][FW-1:0];

      // Exponent all ones with nonzero mantissa
      assign a_nan  = (&a[FW-2:MAN_BITS]) & (|a[MAN_BITS-1:0]);
      assign b_nan  = (&b[FW-2:MAN_BITS]) & (|b[MAN_BITS-1:0]);
      assign a_snan = a_nan & ~a[MAN_BITS-1]; // Quiet bit clear
      assign b_snan = b_nan & ~b[MAN_BITS-1];

      assign qnan = {1'b0, {(FW-MAN_BITS){1'b1}}, {(MAN_BITS-1){1'b0}}};

      always_comb begin : min_max
        // Sign-magnitude compare, -0 sorts below +0
        if (a[FW-1] != b[FW-1]) begin
          a_lt_b = a[FW-1];
        end else if (a[FW-1]) begin
          a_lt_b = a[FW-2:0] > b[FW-2:0];
        end else begin
          a_lt_b = a[FW-2:0] < b[FW-2:0];
        end
        take_a = (op_i == FMIN) ? a_lt_b : ~a_lt_b;

        if (a_nan && b_nan) begin
          minmax = qnan;
        end else if (a_nan) begin
          minmax = b; // Single NaN yields the number
        end else if (b_nan) begin
          minmax = a;
        end else begin
          minmax = take_a ? a : b;
        end
      end

      always_comb begin : op_select
        res_word = '1; // NaN-box above the format
        unique case (op_i)
          SGNJ:    res_word[FW-1:0] = {b[FW-1], a[FW-2:0]};
          SGNJN:   res_word[FW-1:0] = {~b[FW-1], a[FW-2:0]};
          SGNJX:   res_word[FW-1:0] = {a[FW-1] ^ b[FW-1], a[FW-2:0]};
          default: res_word[FW-1:0] = minmax;
        endcase
      end

      assign fmt_result[f] = res_word;
      assign fmt_nv[f]     = ((op_i == FMIN) | (op_i == FMAX)) & (a_snan | b_snan);
    end else begin : gen_inactive
      assign fmt_result[f] = '1;
      assign fmt_nv[f]     = 1'b0;
    end
  end

  always_comb begin : build_status
    lane_status    = '0;
    lane_status.nv = fmt_nv[fmt_i]; // Only NV can fire here
  end

  assign body_in = {fmt_result[fmt_i], lane_status, mask_i};

  // --------------------
  // Pipeline
  // --------------------
  if (LaneIdx == 0) begin : gen_head
    head_t head_in, head_out;

    assign head_in = {body_in, tag_i, aux_i};

    slice_pipe #(
      .NumPipeRegs ( NumPipeRegs ),
      .payload_t   ( head_t      )
    ) u_pipe (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .flush_i     ( flush_i     ),
      .in_valid_i  ( in_valid_i  ),
      .in_ready_o  ( in_ready_o  ),
      .data_i      ( head_in     ),
      .out_valid_o ( out_valid   ),
      .out_ready_i ( out_ready_i ),
      .data_o      ( head_out    ),
      .busy_o      ( busy_o      )
    );

    assign body_out = head_out.body;
    assign tag_o    = head_out.tag;
    assign res.aux  = head_out.aux;
  end else begin : gen_body
    slice_pipe #(
      .NumPipeRegs ( NumPipeRegs ),
      .payload_t   ( body_t      )
    ) u_pipe (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .flush_i     ( flush_i     ),
      .in_valid_i  ( in_valid_i  ),
      .in_ready_o  ( in_ready_o  ),
      .data_i      ( body_in     ),
      .out_valid_o ( out_valid   ),
      .out_ready_i ( out_ready_i ),
      .data_o      ( body_out    ),
      .busy_o      ( busy_o      )
    );

    assign tag_o = '0; // Tag lives in lane 0
  end

  always_comb begin : widen_result
    lane_word                 = '1;
    lane_word[LANE_WIDTH-1:0] = body_out.result;
  end

  assign res.lane_result[LaneIdx] = lane_word;
  assign res.lane_status[LaneIdx] = body_out.status;
  assign res.lane_mask[LaneIdx]   = body_out.mask;
  assign res.lane_valid[LaneIdx]  = out_valid;

endmodule

`default_nettype wire

/* source/noncomp_slice.sv */
// --------------------
// Non-computational FP slice
// SIMD lanes for sign injection and min/max with result packing
// --------------------

`timescale 1ns/100ps
`default_nettype none

module noncomp_slice #(
  parameter int unsigned Width       = 64,
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  // Upstream side
  input  logic [1:0][Width-1:0]                       operands_i,
  input  fpslice_pkg::noncomp_op_e                    op_i,
  input  fpslice_pkg::fp_format_e                     fmt_i,
  input  logic                                        vectorial_op_i,
  input  logic [TagWidth-1:0]                         tag_i,
  input  logic [fpslice_pkg::num_lanes(Width)-1:0]    simd_mask_i,
  input  logic                                        in_valid_i,
  output logic                                        in_ready_o,
  input  logic                                        flush_i,
  // Downstream side
  output logic [Width-1:0]                            result_o,
  output fpslice_pkg::status_t                        status_o,
  output logic [TagWidth-1:0]                         tag_o,
  output logic                                        out_valid_o,
  input  logic                                        out_ready_i,
  output logic                                        busy_o
);

  import fpslice_pkg::*;

  localparam int unsigned NUM_LANES = num_lanes(Width);

  lane_result_if #(.NumLanes(NUM_LANES)) lane_if ();

  aux_t                               aux_in;
  logic [NUM_LANES-1:0]               lane_in_valid, lane_in_ready;
  logic [NUM_LANES-1:0]               lane_out_ready, lane_busy;
  logic [NUM_LANES-1:0][TagWidth-1:0] lane_tag;

  assign aux_in = {vectorial_op_i, fmt_i};

  // --------------------
  // Lanes
  // --------------------
  for (genvar l = 0; l < int'(NUM_LANES); l++) begin : gen_lane
    localparam logic [NUM_FORMATS-1:0] FMTS = lane_formats(Width, l);

    // Upper lanes join only vector ops of a format they hold
    assign lane_in_valid[l]  = in_valid_i & ((l == 0) | (vectorial_op_i & FMTS[fmt_i]));
    assign lane_out_ready[l] = out_ready_i & ((l == 0) | lane_if.aux.is_vector);

    noncomp_lane #(
      .Width       ( Width       ),
      .NumPipeRegs ( NumPipeRegs ),
      .TagWidth    ( TagWidth    ),
      .LaneIdx     ( l           )
    ) u_lane (
      .clk_i       ( clk_i             ),
      .rst_n_i     ( rst_n_i           ),
      .flush_i     ( flush_i           ),
      .operands_i  ( operands_i        ),
      .op_i        ( op_i              ),
      .fmt_i       ( fmt_i             ),
      .aux_i       ( aux_in            ),
      .tag_i       ( tag_i             ),
      .mask_i      ( simd_mask_i[l]    ),
      .in_valid_i  ( lane_in_valid[l]  ),
      .in_ready_o  ( lane_in_ready[l]  ),
      .out_ready_i ( lane_out_ready[l] ),
      .tag_o       ( lane_tag[l]       ),
      .busy_o      ( lane_busy[l]      ),
      .res         ( lane_if.lane_mp   )
    );
  end

  // --------------------
  // Output side
  // --------------------
  result_packer #(
    .Width ( Width )
  ) u_packer (
    .res      ( lane_if.packer_mp ),
    .result_o ( result_o          ),
    .status_o ( status_o          )
  );

  assign in_ready_o  = lane_in_ready[0];       // Lane 0 speaks for the slice
  assign out_valid_o = lane_if.lane_valid[0];
  assign tag_o       = lane_tag[0];
  assign busy_o      = |lane_busy;

endmodule

`default_nettype wire

/* source/result_packer.sv */
// --------------------
// Result packer
// NaN-boxed per-format words and masked status collapse
// --------------------

`timescale 1ns/100ps
`default_nettype none

module result_packer #(
  parameter int unsigned Width = 64
) (
  lane_result_if.packer_mp      res,
  output logic [Width-1:0]      result_o,
  output fpslice_pkg::status_t  status_o
);

  import fpslice_pkg::*;

  localparam int unsigned NUM_LANES = num_lanes(Width);

  logic [NUM_LANES-1:0] lane_active;
  logic [Width-1:0]     fmt_word [NUM_FORMATS];

  // Upper lanes only count for vector results
  always_comb begin : active_lanes
    for (int l = 0; l < int'(NUM_LANES); l++) begin
      lane_active[l] = res.lane_valid[l] & ((l == 0) | res.aux.is_vector);
    end
  end

  // --------------------
  // Per-format packing
  // --------------------
  for (genvar f = 0; f < int'(NUM_FORMATS); f++) begin : gen_fmt
    localparam int unsigned FW = fp_width(fp_format_e'(f));

    for (genvar l = 0; l < int'(NUM_LANES); l++) begin : gen_lane
      localparam logic [NUM_FORMATS-1:0] FMTS = lane_formats(Width, l);

      // Lanes beyond the format's reach fall outside the word
      if (FMTS[f]) begin : gen_slot
        assign fmt_word[f][l*FW +: FW] = lane_active[l] ? res.lane_result[l][FW-1:0]
                                                        : {FW{1'b1}};
      end
    end
  end

  assign result_o = fmt_word[res.aux.fmt];

  // --------------------
  // Status
  // --------------------
  always_comb begin : collapse_status
    status_o = '0;
    for (int l = 0; l < int'(NUM_LANES); l++) begin
      if (lane_active[l] && res.lane_mask[l]) begin
        status_o = status_o | res.lane_status[l];
      end
    end
  end

endmodule

`default_nettype wire

/* source/slice_pipe.sv */
// --------------------
// Valid/ready register pipeline
// NumPipeRegs stages, bubble collapsing, synchronous flush
// --------------------

`timescale 1ns/100ps
`default_nettype none

module slice_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         payload_t   = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t data_o,
  output logic     busy_o
);

  // Index i is the state after i register stages
  payload_t stage_data  [NumPipeRegs+1];
  logic     stage_valid [NumPipeRegs+1];
  logic     stage_ready [NumPipeRegs+1];

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = in_valid_i;

  for (genvar i = 0; i < int'(NumPipeRegs); i++) begin : gen_stage
    logic load;

    // Advance if downstream takes our item or holds only a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i) begin : valid_reg
      if (!rst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0; // Drop everything in flight
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Output side
  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o               = stage_ready[0];
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign data_o                   = stage_data[NumPipeRegs];

  always_comb begin : busy_scan
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

endmodule

`default_nettype wire
